/* list.f */
+incdir+logic
logic/cart_pkg.sv
logic/boot_menu.sv
logic/nrom_map.sv
logic/uxrom_map.sv
logic/prg_port.sv
logic/chr_port.sv
logic/map_mux.sv
logic/cart_top.sv
verification/cart_mem_model.sv
verification/cart_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cart_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/cart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_tb;

    localparam int T_RESET = 12;
    localparam int T_SELECT = 6;  // one mapper switch incl. the wait for ack
    localparam int T_HANDSHAKE = 12 * (T_SELECT + 6);
    localparam int T_BANKING = T_SELECT + 8 * 5;
    localparam int T_CHR = 2 * T_SELECT + 12 * 2 + 8 * 2;
    localparam int T_MIRROR = 3 * (T_SELECT + 16 + 4);
    localparam int CYCLE_LIMIT = 2 * (T_RESET + T_HANDSHAKE + T_BANKING + T_CHR + T_MIRROR + 4);

    logic m2;
    logic async_reset;
    cart_pkg::cpu_addr_t cpu_addr;
    cart_pkg::byte_t cpu_data_in;
    logic cpu_rw;
    cart_pkg::byte_t cpu_data_out;
    logic cpu_oe;
    cart_pkg::ppu_addr_t ppu_addr;
    cart_pkg::byte_t ppu_data_in;
    logic ppu_rd;
    logic ppu_wr;
    cart_pkg::byte_t ppu_data_out;
    logic ppu_oe;
    logic ciram_a10;
    logic ciram_ce;
    logic [23:0] map_ctrl;
    logic map_ctrl_req;
    logic map_ctrl_ack;
    cart_pkg::mem_addr_t prg_mem_addr;
    logic prg_mem_rd;
    cart_pkg::byte_t prg_mem_rdata;
    cart_pkg::mem_addr_t chr_mem_addr;
    logic chr_mem_rd;
    logic chr_mem_we;
    cart_pkg::byte_t chr_mem_wdata;
    cart_pkg::byte_t chr_mem_rdata;

    // host side view of the cartridge state
    cart_pkg::map_sel_t cur_sel;
    cart_pkg::map_args_t cur_args;
    logic [4:0] cur_bank;
    logic busy;  // a mapper switch is in flight
    cart_pkg::byte_t exp_prg;
    cart_pkg::mem_addr_t exp_prg_addr;
    cart_pkg::byte_t exp_chr;
    cart_pkg::mem_addr_t exp_chr_addr;
    cart_pkg::byte_t chr_shadow [cart_pkg::mem_addr_t];
    int errors;
    int accesses;
    int cycles;

    cart_top i_cart_top (
        .m2 (m2), .async_reset (async_reset),
        .cpu_addr (cpu_addr), .cpu_data_in (cpu_data_in), .cpu_rw (cpu_rw),
        .cpu_data_out (cpu_data_out), .cpu_oe (cpu_oe),
        .ppu_addr (ppu_addr), .ppu_data_in (ppu_data_in), .ppu_rd (ppu_rd), .ppu_wr (ppu_wr),
        .ppu_data_out (ppu_data_out), .ppu_oe (ppu_oe),
        .ciram_a10 (ciram_a10), .ciram_ce (ciram_ce),
        .map_ctrl (map_ctrl), .map_ctrl_req (map_ctrl_req), .map_ctrl_ack (map_ctrl_ack),
        .prg_mem_addr (prg_mem_addr), .prg_mem_rd (prg_mem_rd), .prg_mem_rdata (prg_mem_rdata),
        .chr_mem_addr (chr_mem_addr), .chr_mem_rd (chr_mem_rd), .chr_mem_we (chr_mem_we),
        .chr_mem_wdata (chr_mem_wdata), .chr_mem_rdata (chr_mem_rdata)
    );

    cart_mem_model i_prg_mem (
        .m2 (m2), .addr (prg_mem_addr), .rd (prg_mem_rd),
        .we (1'b0), .wdata (8'h00), .rdata (prg_mem_rdata)
    );

    cart_mem_model i_chr_mem (
        .m2 (m2), .addr (chr_mem_addr), .rd (chr_mem_rd),
        .we (chr_mem_we), .wdata (chr_mem_wdata), .rdata (chr_mem_rdata)
    );

    initial begin
        m2 = 1'b0;
        forever #2 m2 = ~m2;
    end

    function automatic cart_pkg::byte_t fill_byte(input cart_pkg::mem_addr_t a);
        return 8'(a ^ (a >> 8) ^ (a >> 16));
    endfunction

    function automatic cart_pkg::mem_addr_t prg_expect(input cart_pkg::cpu_addr_t a);
        logic [31:0] full;
        logic [4:0] bank;
        bank = (a[15:14] == 2'b11) ? 5'd31 : cur_bank;
        if (cur_sel == 5'd2) begin
            full = 32'(bank) * 32'd16384 + 32'(a[13:0]);
        end else begin
            full = 32'(a) - 32'h8000;
        end
        full = full & ((32'd1 << cur_args[4:0]) - 32'd1);  // PRG window below 2^chr_off
        return cart_pkg::mem_addr_t'(full);
    endfunction

    function automatic cart_pkg::mem_addr_t chr_expect(input cart_pkg::ppu_addr_t a);
        return cart_pkg::mem_addr_t'(a[12:0]) | (cart_pkg::mem_addr_t'(1) << cur_args[4:0]);
    endfunction

    function automatic cart_pkg::map_args_t pick_args();
        return {1'b0, 1'($urandom_range(1, 0)), 5'($urandom_range(22, 15))};
    endfunction

    task automatic flag_error(input string what);
        errors++;
        $display("[ERROR] %0t: %s", $time, what);
    endtask

    task automatic park_bus();
        cpu_addr = 16'h0000;
        cpu_rw = 1'b1;
        ppu_rd = 1'b0;
        ppu_wr = 1'b0;
    endtask

    task automatic switch_mapper(input cart_pkg::map_sel_t sel, input cart_pkg::map_args_t args);
        @(negedge m2);
        park_bus();
        busy = 1'b1;
        map_ctrl = {12'h000, args, sel};
        map_ctrl_req = !map_ctrl_req;
        while (map_ctrl_ack != map_ctrl_req) @(negedge m2);
        if (sel != cur_sel) cur_bank = 5'd0;  // leaving a slot resets it
        cur_sel = sel;
        cur_args = args;
        busy = 1'b0;
    endtask

    task automatic cpu_read(input cart_pkg::cpu_addr_t a);
        @(negedge m2);
        park_bus();
        cpu_addr = a;
        exp_prg_addr = prg_expect(a);
        exp_prg = fill_byte(exp_prg_addr);
        accesses++;
    endtask

    task automatic cpu_write(input cart_pkg::cpu_addr_t a, input cart_pkg::byte_t d);
        @(negedge m2);
        park_bus();
        cpu_addr = a;
        cpu_rw = 1'b0;
        cpu_data_in = d;
        if (cur_sel == 5'd2 && a[15]) cur_bank = d[4:0];
        accesses++;
    endtask

    task automatic ppu_read(input cart_pkg::ppu_addr_t a);
        @(negedge m2);
        park_bus();
        ppu_addr = a;
        ppu_rd = 1'b1;
        exp_chr_addr = chr_expect(a);
        if (chr_shadow.exists(exp_chr_addr)) begin
            exp_chr = chr_shadow[exp_chr_addr];
        end else begin
            exp_chr = fill_byte(exp_chr_addr);
        end
        accesses++;
    endtask

    task automatic ppu_write(input cart_pkg::ppu_addr_t a, input cart_pkg::byte_t d);
        @(negedge m2);
        park_bus();
        ppu_addr = a;
        ppu_wr = 1'b1;
        ppu_data_in = d;
        exp_chr_addr = chr_expect(a);
        if ((cur_sel == 5'd0 || cur_sel == 5'd2) && !a[13]) begin
            chr_shadow[exp_chr_addr] = d;  // CHR RAM
        end
        accesses++;
    endtask

    a_reset_state: assert property (@(posedge m2)
        $fell(async_reset) |-> !cpu_oe && !ppu_oe && !map_ctrl_ack)
        else flag_error("outputs not idle after reset");

    // ack follows the req sampled three edges earlier and moves at no other time
    a_ack_timing: assert property (@(posedge m2) disable iff (async_reset)
        $changed(map_ctrl_ack) |->
            map_ctrl_ack == $past(map_ctrl_req, 3) && map_ctrl_ack != $past(map_ctrl_req, 4))
        else flag_error("map_ctrl_ack moved off the three edge handshake");

    a_prg_fetch: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel <= 5'd2 && cpu_rw && cpu_addr[15]) |->
            prg_mem_rd && prg_mem_addr == exp_prg_addr)
        else flag_error("PRG memory strobe or address wrong");

    a_prg_idle: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && (cur_sel > 5'd2 || !(cpu_rw && cpu_addr[15]))) |-> !prg_mem_rd)
        else flag_error("PRG memory read without a CPU read");

    a_prg_read: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel <= 5'd2 && cpu_rw && cpu_addr[15]) |=>
            cpu_oe && cpu_data_out == $past(exp_prg))
        else flag_error("cpu read data or cpu_oe wrong");

    a_empty_slot: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel > 5'd2) |=> !cpu_oe && !ppu_oe)
        else flag_error("empty slot drove the bus");

    a_chr_fetch: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel <= 5'd2 && ppu_rd && !ppu_addr[13]) |->
            chr_mem_rd && chr_mem_addr == exp_chr_addr)
        else flag_error("CHR memory strobe or address wrong");

    a_chr_idle: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && (cur_sel > 5'd2 || !ppu_rd)) |-> !chr_mem_rd)
        else flag_error("CHR memory read without a PPU read");

    a_chr_read: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel <= 5'd2 && ppu_rd && !ppu_addr[13]) |=>
            ppu_oe && ppu_data_out == $past(exp_chr))
        else flag_error("ppu read data or ppu_oe wrong");

    a_chr_write: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && (cur_sel == 5'd0 || cur_sel == 5'd2) && ppu_wr && !ppu_addr[13]) |->
            chr_mem_we && chr_mem_addr == exp_chr_addr && chr_mem_wdata == ppu_data_in)
        else flag_error("CHR RAM write missing or misplaced");

    a_nrom_rom: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel == 5'd1 && ppu_wr) |-> !chr_mem_we)
        else flag_error("NROM wrote into CHR ROM");

    // boot menu ignores args[5]
    a_mirroring: assert property (@(posedge m2) disable iff (async_reset)
        (!busy && cur_sel <= 5'd2) |-> ciram_ce == !ppu_addr[13] &&
            ciram_a10 == ((cur_sel != 5'd0 && cur_args[5]) ? ppu_addr[10] : ppu_addr[11]))
        else flag_error("CIRAM mirroring wrong");

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge m2);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests never finished", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        cart_pkg::map_sel_t sel;
        cart_pkg::ppu_addr_t pa;
        void'($urandom(10477));
        async_reset = 1'b1;
        park_bus();
        cpu_data_in = 8'h00;
        ppu_addr = '0;
        ppu_data_in = 8'h00;
        map_ctrl = '0;
        map_ctrl_req = 1'b0;
        busy = 1'b0;
        cur_sel = '0;
        cur_args = '0;
        cur_bank = '0;
        exp_prg = '0;
        exp_prg_addr = '0;
        exp_chr = '0;
        exp_chr_addr = '0;
        errors = 0;
        accesses = 0;
        repeat (3) @(posedge m2);
        @(negedge m2);
        async_reset = 1'b0;

        // boot menu straight out of reset
        repeat (6) cpu_read(16'h8000 | 16'($urandom_range(32'h7fff, 0)));

        for (int i = 0; i < 12; i++) begin
            case ($urandom_range(2, 0))
                0: sel = 5'd1;
                1: sel = 5'd2;
                default: sel = 5'd7;
            endcase
            switch_mapper(sel, pick_args());
            repeat (3) cpu_read(16'h8000 | 16'($urandom_range(32'h7fff, 0)));
            repeat (2) ppu_read(cart_pkg::ppu_addr_t'($urandom_range(32'h1fff, 0)));
        end

        switch_mapper(5'd2, pick_args());
        for (int i = 0; i < 8; i++) begin
            cpu_write(16'h8000 | 16'($urandom_range(32'h7fff, 0)), 8'($urandom));
            repeat (2) cpu_read(16'h8000 | 16'($urandom_range(32'h3fff, 0)));
            repeat (2) cpu_read(16'hc000 | 16'($urandom_range(32'h3fff, 0)));
        end

        for (int i = 0; i < 12; i++) begin
            pa = cart_pkg::ppu_addr_t'($urandom_range(32'h1fff, 0));
            ppu_write(pa, 8'($urandom));
            ppu_read(pa);
        end
        switch_mapper(5'd1, pick_args());
        for (int i = 0; i < 8; i++) begin
            pa = cart_pkg::ppu_addr_t'($urandom_range(32'h1fff, 0));
            ppu_write(pa, 8'($urandom));
            ppu_read(pa);
        end

        for (int s = 0; s < 3; s++) begin
            switch_mapper(5'(s), pick_args() | 7'h20);  // vertical asked even for the menu
            repeat (4) cpu_read(16'h8000 | 16'($urandom_range(32'h7fff, 0)));
            for (int i = 0; i < 16; i++) begin
                @(negedge m2);
                ppu_addr = cart_pkg::ppu_addr_t'($urandom);
            end
        end

        @(negedge m2);
        park_bus();
        repeat (2) @(negedge m2);
        $display("checks done: %0d accesses, %0d errors", accesses, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/cart_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_mem_model (
    input  wire logic               m2,
    input  cart_pkg::mem_addr_t     addr,
    input  wire logic               rd,
    input  wire logic               we,
    input  cart_pkg::byte_t         wdata,
    output cart_pkg::byte_t         rdata
);

    cart_pkg::byte_t cells [cart_pkg::mem_addr_t];  // only bytes that were written

    // untouched bytes read as the fill pattern, folded over every address bit
    function automatic cart_pkg::byte_t fill_byte(input cart_pkg::mem_addr_t a);
        return 8'(a ^ (a >> 8) ^ (a >> 16));
    endfunction

    always_comb begin
        if (!rd) begin
            rdata = 8'h00;
        end else if (cells.exists(addr)) begin
            rdata = cells[addr];
        end else begin
            rdata = fill_byte(addr);
        end
    end

    // a write cycle never carries a read strobe
    always @(posedge m2) begin
        if (we) begin
            cells[addr] = wdata;
        end
    end

endmodule

`default_nettype wire

/* logic/cart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_top (
    input  wire logic               m2,
    input  wire logic               async_reset,

    input  cart_pkg::cpu_addr_t     cpu_addr,
    input  cart_pkg::byte_t         cpu_data_in,
    input  wire logic               cpu_rw,
    output cart_pkg::byte_t         cpu_data_out,
    output logic                    cpu_oe,

    input  cart_pkg::ppu_addr_t     ppu_addr,
    input  cart_pkg::byte_t         ppu_data_in,
    input  wire logic               ppu_rd,
    input  wire logic               ppu_wr,
    output cart_pkg::byte_t         ppu_data_out,
    output logic                    ppu_oe,
    output logic                    ciram_a10,
    output logic                    ciram_ce,

    input  wire logic [23:0]        map_ctrl,
    input  wire logic               map_ctrl_req,
    output logic                    map_ctrl_ack,

    output cart_pkg::mem_addr_t     prg_mem_addr,
    output logic                    prg_mem_rd,
    input  cart_pkg::byte_t         prg_mem_rdata,

    output cart_pkg::mem_addr_t     chr_mem_addr,
    output logic                    chr_mem_rd,
    output logic                    chr_mem_we,
    output cart_pkg::byte_t         chr_mem_wdata,
    input  cart_pkg::byte_t         chr_mem_rdata
);

    map_mux i_map_mux (
        .m2            (m2),
        .async_reset   (async_reset),
        .cpu_addr      (cpu_addr),
        .cpu_data_in   (cpu_data_in),
        .cpu_rw        (cpu_rw),
        .cpu_data_out  (cpu_data_out),
        .cpu_oe        (cpu_oe),
        .ppu_addr      (ppu_addr),
        .ppu_data_in   (ppu_data_in),
        .ppu_rd        (ppu_rd),
        .ppu_wr        (ppu_wr),
        .ppu_data_out  (ppu_data_out),
        .ppu_oe        (ppu_oe),
        .ciram_a10     (ciram_a10),
        .ciram_ce      (ciram_ce),
        .map_ctrl      (map_ctrl),
        .map_ctrl_req  (map_ctrl_req),
        .map_ctrl_ack  (map_ctrl_ack),
        .prg_mem_addr  (prg_mem_addr),
        .prg_mem_rd    (prg_mem_rd),
        .prg_mem_rdata (prg_mem_rdata),
        .chr_mem_addr  (chr_mem_addr),
        .chr_mem_rd    (chr_mem_rd),
        .chr_mem_we    (chr_mem_we),
        .chr_mem_wdata (chr_mem_wdata),
        .chr_mem_rdata (chr_mem_rdata)
    );

endmodule

`default_nettype wire

/* logic/map_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module map_mux (
    input  wire logic               m2,
    input  wire logic               async_reset,

    input  cart_pkg::cpu_addr_t     cpu_addr,
    input  cart_pkg::byte_t         cpu_data_in,
    input  wire logic               cpu_rw,
    output cart_pkg::byte_t         cpu_data_out,
    output logic                    cpu_oe,

    input  cart_pkg::ppu_addr_t     ppu_addr,
    input  cart_pkg::byte_t         ppu_data_in,
    input  wire logic               ppu_rd,
    input  wire logic               ppu_wr,
    output cart_pkg::byte_t         ppu_data_out,
    output logic                    ppu_oe,
    output logic                    ciram_a10,
    output logic                    ciram_ce,

    input  wire logic [23:0]        map_ctrl,
    input  wire logic               map_ctrl_req,
    output logic                    map_ctrl_ack,

    output cart_pkg::mem_addr_t     prg_mem_addr,
    output logic                    prg_mem_rd,
    input  cart_pkg::byte_t         prg_mem_rdata,

    output cart_pkg::mem_addr_t     chr_mem_addr,
    output logic                    chr_mem_rd,
    output logic                    chr_mem_we,
    output cart_pkg::byte_t         chr_mem_wdata,
    input  cart_pkg::byte_t         chr_mem_rdata
);

    localparam int USED_SLOTS = 3;  // boot menu, NROM, UxROM

    cart_pkg::map_sel_t select;
    cart_pkg::map_args_t args;
    logic [`CART_SYNC_STAGES-1:0] req_sync;
    logic req_new;
    logic [4:0] chr_off;

    logic [USED_SLOTS-1:0] slot_reset;

    cart_pkg::mem_addr_t bus_prg_addr [`CART_MAP_CNT];
    logic bus_prg_oe [`CART_MAP_CNT];
    cart_pkg::mem_addr_t bus_chr_addr [`CART_MAP_CNT];
    logic bus_chr_ce [`CART_MAP_CNT];
    logic bus_chr_oe [`CART_MAP_CNT];
    logic bus_chr_we [`CART_MAP_CNT];
    logic bus_ciram_a10 [`CART_MAP_CNT];
    logic bus_ciram_ce [`CART_MAP_CNT];

    assign chr_off = args[4:0];
    assign req_new = req_sync[`CART_SYNC_STAGES-1] != map_ctrl_ack;

    // host request arrives as a toggle and ack echoes it once synchronized
    always_ff @(posedge m2 or posedge async_reset) begin
        if (async_reset) begin
            req_sync <= '0;
            select <= '0;
            args <= '0;
            map_ctrl_ack <= 1'b0;
        end else begin
            req_sync <= {req_sync[`CART_SYNC_STAGES-2:0], map_ctrl_req};
            if (req_new) begin
                {args, select} <= map_ctrl[11:0];
                map_ctrl_ack <= req_sync[`CART_SYNC_STAGES-1];
            end
        end
    end

    for (genvar n = 0; n < USED_SLOTS; n++) begin : g_slot_reset
        assign slot_reset[n] = async_reset || (select != cart_pkg::map_sel_t'(n));
    end

    boot_menu i_boot_menu (
        .m2 (m2), .reset (slot_reset[0]), .args (args),
        .cpu_addr (cpu_addr), .cpu_data_in (cpu_data_in), .cpu_rw (cpu_rw),
        .ppu_addr (ppu_addr), .ppu_rd (ppu_rd), .ppu_wr (ppu_wr),
        .prg_addr (bus_prg_addr[0]), .prg_oe (bus_prg_oe[0]),
        .chr_addr (bus_chr_addr[0]), .chr_ce (bus_chr_ce[0]),
        .chr_oe (bus_chr_oe[0]), .chr_we (bus_chr_we[0]),
        .ciram_a10 (bus_ciram_a10[0]), .ciram_ce (bus_ciram_ce[0])
    );

    nrom_map i_nrom_map (
        .m2 (m2), .reset (slot_reset[1]), .args (args),
        .cpu_addr (cpu_addr), .cpu_data_in (cpu_data_in), .cpu_rw (cpu_rw),
        .ppu_addr (ppu_addr), .ppu_rd (ppu_rd), .ppu_wr (ppu_wr),
        .prg_addr (bus_prg_addr[1]), .prg_oe (bus_prg_oe[1]),
        .chr_addr (bus_chr_addr[1]), .chr_ce (bus_chr_ce[1]),
        .chr_oe (bus_chr_oe[1]), .chr_we (bus_chr_we[1]),
        .ciram_a10 (bus_ciram_a10[1]), .ciram_ce (bus_ciram_ce[1])
    );

    uxrom_map i_uxrom_map (
        .m2 (m2), .reset (slot_reset[2]), .args (args),
        .cpu_addr (cpu_addr), .cpu_data_in (cpu_data_in), .cpu_rw (cpu_rw),
        .ppu_addr (ppu_addr), .ppu_rd (ppu_rd), .ppu_wr (ppu_wr),
        .prg_addr (bus_prg_addr[2]), .prg_oe (bus_prg_oe[2]),
        .chr_addr (bus_chr_addr[2]), .chr_ce (bus_chr_ce[2]),
        .chr_oe (bus_chr_oe[2]), .chr_we (bus_chr_we[2]),
        .ciram_a10 (bus_ciram_a10[2]), .ciram_ce (bus_ciram_ce[2])
    );

    // empty slots stay silent
    for (genvar n = USED_SLOTS; n < `CART_MAP_CNT; n++) begin : g_empty
        assign bus_prg_addr[n] = '0;
        assign bus_prg_oe[n] = 1'b0;
        assign bus_chr_addr[n] = '0;
        assign bus_chr_ce[n] = 1'b0;
        assign bus_chr_oe[n] = 1'b0;
        assign bus_chr_we[n] = 1'b0;
        assign bus_ciram_a10[n] = 1'b0;
        assign bus_ciram_ce[n] = 1'b0;
    end

    assign ciram_a10 = bus_ciram_a10[select];
    assign ciram_ce = bus_ciram_ce[select];

    prg_port i_prg_port (
        .m2        (m2),
        .async_reset (async_reset),
        .oe        (bus_prg_oe[select]),
        .addr      (bus_prg_addr[select]),
        .chr_off   (chr_off),
        .mem_rdata (prg_mem_rdata),
        .mem_addr  (prg_mem_addr),
        .mem_rd    (prg_mem_rd),
        .data_out  (cpu_data_out),
        .data_oe   (cpu_oe)
    );

    chr_port i_chr_port (
        .m2        (m2),
        .async_reset (async_reset),
        .ce        (bus_chr_ce[select]),
        .oe        (bus_chr_oe[select]),
        .we        (bus_chr_we[select]),
        .addr      (bus_chr_addr[select]),
        .chr_off   (chr_off),
        .data_in   (ppu_data_in),
        .mem_rdata (chr_mem_rdata),
        .mem_addr  (chr_mem_addr),
        .mem_rd    (chr_mem_rd),
        .mem_we    (chr_mem_we),
        .mem_wdata (chr_mem_wdata),
        .data_out  (ppu_data_out),
        .data_oe   (ppu_oe)
    );

    // synchronized req is the pin value from SYNC_STAGES edges before the load
    a_ack_on_req: assert property (@(posedge m2) disable iff (async_reset)
        $changed(map_ctrl_ack) |->
            $past(map_ctrl_req, `CART_SYNC_STAGES + 1) != $past(map_ctrl_ack));

    // host keeps req equal to ack while idle so nothing may move then
    a_select_idle: assert property (@(posedge m2) disable iff (async_reset)
        (map_ctrl_req == map_ctrl_ack) |=> $stable(select));

endmodule

`default_nettype wire

/* logic/chr_port.sv */
`timescale 1ns/1ps
`default_nettype none

module chr_port (
    input  wire logic               m2,
    input  wire logic               async_reset,
    input  wire logic               ce,
    input  wire logic               oe,
    input  wire logic               we,
    input  cart_pkg::mem_addr_t     addr,
    input  wire logic [4:0]         chr_off,
    input  cart_pkg::byte_t         data_in,
    input  cart_pkg::byte_t         mem_rdata,
    output cart_pkg::mem_addr_t     mem_addr,
    output logic                    mem_rd,
    output logic                    mem_we,
    output cart_pkg::byte_t         mem_wdata,
    output cart_pkg::byte_t         data_out,
    output logic                    data_oe
);

    logic rd_cycle;

    assign rd_cycle = ce && oe;

    // CHR window starts at 2^chr_off, right above PRG
    assign mem_addr = addr | (cart_pkg::mem_addr_t'(1) << chr_off);
    assign mem_rd = rd_cycle;
    assign mem_we = ce && we;  // written at the edge closing this cycle
    assign mem_wdata = data_in;

    always_ff @(posedge m2 or posedge async_reset) begin
        if (async_reset) begin
            data_oe <= 1'b0;
        end else begin
            data_oe <= rd_cycle;
        end
    end

    always_ff @(posedge m2) begin
        data_out <= mem_rdata;
    end

    // the PPU never strobes read and write in one cycle
    a_rd_wr_excl: assert property (@(posedge m2) disable iff (async_reset)
        !(we && oe));

endmodule

`default_nettype wire

/* logic/prg_port.sv */
`timescale 1ns/1ps
`default_nettype none

module prg_port (
    input  wire logic               m2,
    input  wire logic               async_reset,
    input  wire logic               oe,
    input  cart_pkg::mem_addr_t     addr,
    input  wire logic [4:0]         chr_off,
    input  cart_pkg::byte_t         mem_rdata,
    output cart_pkg::mem_addr_t     mem_addr,
    output logic                    mem_rd,
    output cart_pkg::byte_t         data_out,
    output logic                    data_oe
);

    cart_pkg::mem_addr_t win_mask;

    // PRG lives below the CHR window base
    assign win_mask = (cart_pkg::mem_addr_t'(1) << chr_off) - cart_pkg::mem_addr_t'(1);
    assign mem_addr = addr & win_mask;
    assign mem_rd = oe;

    always_ff @(posedge m2 or posedge async_reset) begin
        if (async_reset) begin
            data_oe <= 1'b0;
        end else begin
            data_oe <= oe;
        end
    end

    always_ff @(posedge m2) begin
        data_out <= mem_rdata;  // memory answers in the same cycle
    end

    a_oe_data: assert property (@(posedge m2) disable iff (async_reset)
        data_oe |-> !$isunknown(data_out));

endmodule

`default_nettype wire

/* logic/uxrom_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module uxrom_map (
    input  wire logic               m2,
    input  wire logic               reset,
    input  cart_pkg::map_args_t     args,
    input  cart_pkg::cpu_addr_t     cpu_addr,
    input  cart_pkg::byte_t         cpu_data_in,
    input  wire logic               cpu_rw,
    input  cart_pkg::ppu_addr_t     ppu_addr,
    input  wire logic               ppu_rd,
    input  wire logic               ppu_wr,
    output cart_pkg::mem_addr_t     prg_addr,
    output logic                    prg_oe,
    output cart_pkg::mem_addr_t     chr_addr,
    output logic                    chr_ce,
    output logic                    chr_oe,
    output logic                    chr_we,
    output logic                    ciram_a10,
    output logic                    ciram_ce
);

    logic [4:0] bank;
    logic [4:0] bank_sel;

    // any write to $8000-$FFFF hits the bank latch
    always_ff @(posedge m2 or posedge reset) begin
        if (reset) begin
            bank <= '0;
        end else if (!cpu_rw && cpu_addr[15]) begin
            bank <= cpu_data_in[4:0];
        end
    end

    assign bank_sel = cpu_addr[14] ? 5'h1f : bank;  // $C000 up is fixed to the last bank

    assign prg_oe = cpu_rw && cpu_addr[15];
    assign prg_addr = cart_pkg::mem_addr_t'({bank_sel, cpu_addr[`CART_PRG_BANK_BITS-1:0]});

    // CHR RAM
    assign chr_ce = !ppu_addr[13];
    assign chr_oe = ppu_rd;
    assign chr_we = ppu_wr;
    assign chr_addr = cart_pkg::mem_addr_t'(ppu_addr[12:0]);

    assign ciram_ce = !ppu_addr[13];
    assign ciram_a10 = args[5] ? ppu_addr[10] : ppu_addr[11];

    a_bank_known: assert property (@(posedge m2) !reset |-> !$isunknown(bank));

endmodule

`default_nettype wire

/* logic/nrom_map.sv */
`timescale 1ns/1ps
`default_nettype none

module nrom_map (
    input  wire logic               m2,
    input  wire logic               reset,
    input  cart_pkg::map_args_t     args,
    input  cart_pkg::cpu_addr_t     cpu_addr,
    input  cart_pkg::byte_t         cpu_data_in,
    input  wire logic               cpu_rw,
    input  cart_pkg::ppu_addr_t     ppu_addr,
    input  wire logic               ppu_rd,
    input  wire logic               ppu_wr,
    output cart_pkg::mem_addr_t     prg_addr,
    output logic                    prg_oe,
    output cart_pkg::mem_addr_t     chr_addr,
    output logic                    chr_ce,
    output logic                    chr_oe,
    output logic                    chr_we,
    output logic                    ciram_a10,
    output logic                    ciram_ce
);

    assign prg_oe = cpu_rw && cpu_addr[15];
    assign prg_addr = cart_pkg::mem_addr_t'(cpu_addr[14:0]);  // 16K images wrap via chr_off

    // CHR ROM, a PPU write cycle leaves it deselected
    assign chr_ce = !ppu_addr[13] && !ppu_wr;
    assign chr_oe = ppu_rd;
    assign chr_we = 1'b0;
    assign chr_addr = cart_pkg::mem_addr_t'(ppu_addr[12:0]);

    assign ciram_ce = !ppu_addr[13];
    assign ciram_a10 = args[5] ? ppu_addr[10] : ppu_addr[11];

    a_wr_known: assert property (@(posedge m2) disable iff (reset)
        (!cpu_rw && cpu_addr[15]) |-> !$isunknown(cpu_data_in));

endmodule

`default_nettype wire

/* logic/boot_menu.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_menu (
    input  wire logic               m2,
    input  wire logic               reset,
    input  cart_pkg::map_args_t     args,
    input  cart_pkg::cpu_addr_t     cpu_addr,
    input  cart_pkg::byte_t         cpu_data_in,
    input  wire logic               cpu_rw,
    input  cart_pkg::ppu_addr_t     ppu_addr,
    input  wire logic               ppu_rd,
    input  wire logic               ppu_wr,
    output cart_pkg::mem_addr_t     prg_addr,
    output logic                    prg_oe,
    output cart_pkg::mem_addr_t     chr_addr,
    output logic                    chr_ce,
    output logic                    chr_oe,
    output logic                    chr_we,
    output logic                    ciram_a10,
    output logic                    ciram_ce
);

    // 32 KiB menu image at $8000-$FFFF
    assign prg_oe = cpu_rw && cpu_addr[15];
    assign prg_addr = cart_pkg::mem_addr_t'(cpu_addr[14:0]);

    // 8 KiB CHR RAM, the menu draws its own tiles
    assign chr_ce = !ppu_addr[13];
    assign chr_oe = ppu_rd;
    assign chr_we = ppu_wr;
    assign chr_addr = cart_pkg::mem_addr_t'(ppu_addr[12:0]);

    assign ciram_ce = !ppu_addr[13];
    assign ciram_a10 = ppu_addr[11];  // horizontal only

    // writes to the menu window are dropped, but the bus must still be sane
    a_wr_known: assert property (@(posedge m2) disable iff (reset)
        (!cpu_rw && cpu_addr[15]) |-> !$isunknown({args, cpu_data_in}));

endmodule

`default_nettype wire

/* logic/cart_pkg.sv */
`default_nettype none

`include "cart_consts.svh"

package cart_pkg;

    typedef logic [`CART_ADDR_BITS-1:0] mem_addr_t;  // byte address into the external memory

    typedef logic [$clog2(`CART_MAP_CNT)-1:0] map_sel_t;  // mapper slot

    // [4:0] chr_off, [5] vertical mirroring, [6] reserved
    typedef logic [6:0] map_args_t;

    typedef logic [7:0] byte_t;

    typedef logic [15:0] cpu_addr_t;

    typedef logic [13:0] ppu_addr_t;

endpackage

`default_nettype wire

/* logic/cart_consts.svh */
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// memory byte address width, covers PRG and CHR windows
`define CART_ADDR_BITS 23

// mapper select space
`define CART_MAP_CNT 32

// 16 KiB PRG bank
`define CART_PRG_BANK_BITS 14

// flops on the host request toggle
`define CART_SYNC_STAGES 2

`endif
